// ==== hw/aw_cdc_pkg.sv ====
// Shared types and widths for the AW clock-domain bridge.
// The descriptor layout keeps the AW field order of the existing FIFO:
// id in the top bits and burst in the bottom two.
`default_nettype none

package aw_cdc_pkg;

    localparam int addr_w = 32;
    localparam int id_w   = 8;
    localparam int len_w  = 4;
    localparam int size_w = 3;

    // Saturating reject and drop counters
    localparam int cnt_w = 8;

    // AXI AWBURST encoding
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10,
        burst_rsvd  = 2'b11
    } burst_e;

    // 49-bit AW descriptor
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        // Beats minus one
        logic [len_w-1:0]  len;
        // log2 of bytes per beat
        logic [size_w-1:0] size;
        burst_e            burst;
    } aw_desc_t;

    // One expanded beat, 41 bits
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic              last;
    } aw_beat_t;

endpackage : aw_cdc_pkg

`default_nettype wire

// ==== hw/gray_sync.sv ====
// Two-flop synchronizer for a Gray-coded FIFO pointer.
// The input must change by at most one bit per source clock.
`default_nettype none

module gray_sync #(
    parameter int width = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] gray_in,
    output logic [width-1:0] bin_out
);

    logic [width-1:0] meta;
    logic [width-1:0] gray_sync_q;

    // First flop may go metastable
    always_ff @(posedge clk) begin
        if (rst) begin
            meta        <= '0;
            gray_sync_q <= '0;
        end else begin
            meta        <= gray_in;
            gray_sync_q <= meta;
        end
    end

    // Gray to binary, MSB down
    always_comb begin
        bin_out[width-1] = gray_sync_q[width-1];
        for (int i = width - 2; i >= 0; i--) begin
            bin_out[i] = bin_out[i+1] ^ gray_sync_q[i];
        end
    end

endmodule : gray_sync

`default_nettype wire

// ==== hw/aw_async_fifo.sv ====
// Dual-clock FIFO of AW descriptors, depth 2**fifo_aw.
// Writes on every push and pops on every pop; callers check full and empty.
// Flags are conservative and settle 2 to 3 cycles after the far side moves.
`default_nettype none

module aw_async_fifo #(
    parameter int fifo_aw = 2
) (
    input  logic                 wclk,
    input  logic                 wrst,
    input  logic                 push,
    input  aw_cdc_pkg::aw_desc_t wdata,
    output logic                 full,

    input  logic                 rclk,
    input  logic                 rrst,
    input  logic                 pop,
    output aw_cdc_pkg::aw_desc_t rdata,
    output logic                 empty
);

    import aw_cdc_pkg::*;

    // One extra wrap bit on each pointer
    localparam int ptr_w = fifo_aw + 1;
    localparam int depth = 1 << fifo_aw;

    aw_desc_t mem [0:depth-1];

    // Write side
    logic [ptr_w-1:0] wptr;
    logic [ptr_w-1:0] wptr_gray;
    logic [ptr_w-1:0] wptr_gray_r;
    logic [ptr_w-1:0] rptr_wclk;

    // Read side
    logic [ptr_w-1:0] rptr;
    logic [ptr_w-1:0] rptr_gray;
    logic [ptr_w-1:0] rptr_gray_r;
    logic [ptr_w-1:0] wptr_rclk;

    assign wptr_gray = wptr ^ (wptr >> 1);
    assign rptr_gray = rptr ^ (rptr >> 1);

    // Gray value is registered before it crosses so no logic glitch reaches the sync
    always_ff @(posedge wclk) begin
        if (wrst) begin
            wptr_gray_r <= '0;
        end else begin
            wptr_gray_r <= wptr_gray;
        end
    end

    always_ff @(posedge rclk) begin
        if (rrst) begin
            rptr_gray_r <= '0;
        end else begin
            rptr_gray_r <= rptr_gray;
        end
    end

    gray_sync #(
        .width(ptr_w)
    ) u_wptr_sync (
        .clk    (rclk),
        .rst    (rrst),
        .gray_in(wptr_gray_r),
        .bin_out(wptr_rclk)
    );

    gray_sync #(
        .width(ptr_w)
    ) u_rptr_sync (
        .clk    (wclk),
        .rst    (wrst),
        .gray_in(rptr_gray_r),
        .bin_out(rptr_wclk)
    );

    // Full when wrap bits differ and the index bits match
    assign full = (wptr[ptr_w-1] != rptr_wclk[ptr_w-1]) &&
                  (wptr[ptr_w-2:0] == rptr_wclk[ptr_w-2:0]);
    assign empty = (rptr == wptr_rclk);

    // Storage
    always_ff @(posedge wclk) begin
        if (push) begin
            mem[wptr[fifo_aw-1:0]] <= wdata;
        end
    end

    always_ff @(posedge wclk) begin
        if (wrst) begin
            wptr <= '0;
        end else if (push) begin
            wptr <= wptr + 1'b1;
        end
    end

    always_ff @(posedge rclk) begin
        if (rrst) begin
            rptr <= '0;
        end else if (pop) begin
            rptr <= rptr + 1'b1;
        end
    end

    // Show-ahead head entry
    assign rdata = mem[rptr[fifo_aw-1:0]];

endmodule : aw_async_fifo

`default_nettype wire

// ==== hw/aw_admit.sv ====
// Write-side gate in front of the AW FIFO; no back-pressure to the source.
// Illegal strobes are rejected, legal ones meeting a full FIFO are dropped.
// A legal strobe while the previous push is still pending counts as a drop,
// since full does not yet include that write.
`default_nettype none

module aw_admit #(
    parameter int max_size = 2
) (
    input  logic                         wclk,
    input  logic                         wrst,
    input  logic                         aw_valid,
    input  aw_cdc_pkg::aw_desc_t         aw_in,
    input  logic                         full,
    output logic                         push,
    output aw_cdc_pkg::aw_desc_t         wdata,
    output logic [aw_cdc_pkg::cnt_w-1:0] reject_count,
    output logic [aw_cdc_pkg::cnt_w-1:0] drop_count
);

    import aw_cdc_pkg::*;

    logic              bad_burst;
    logic              bad_size;
    logic              bad_wrap;
    logic [addr_w-1:0] align_mask;
    logic              legal;
    logic              accept;
    logic              drop;
    logic              reject;

    // Low address bits that must be zero for a WRAP start
    assign align_mask = ({{(addr_w-1){1'b0}}, 1'b1} << aw_in.size) - 1'b1;

    assign bad_burst = (aw_in.burst == burst_rsvd);
    assign bad_size  = (aw_in.size > size_w'(max_size));
    assign bad_wrap  = (aw_in.burst == burst_wrap) &&
                       (!(aw_in.len inside {4'd1, 4'd3, 4'd7, 4'd15}) ||
                        ((aw_in.addr & align_mask) != '0));
    assign legal     = !bad_burst && !bad_size && !bad_wrap;

    assign reject = aw_valid && !legal;
    assign accept = aw_valid && legal && !full && !push;
    assign drop   = aw_valid && legal && (full || push);

    always_ff @(posedge wclk) begin
        if (wrst) begin
            push <= 1'b0;
        end else begin
            push <= accept;
        end
    end

    always_ff @(posedge wclk) begin
        if (accept) begin
            wdata <= aw_in;
        end
    end

    // Both counters stick at all ones
    always_ff @(posedge wclk) begin
        if (wrst) begin
            reject_count <= '0;
            drop_count   <= '0;
        end else begin
            if (reject && (reject_count != {cnt_w{1'b1}})) begin
                reject_count <= reject_count + 1'b1;
            end
            if (drop && (drop_count != {cnt_w{1'b1}})) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule : aw_admit

`default_nettype wire

// ==== hw/aw_beat_gen.sv ====
// Expands each AW descriptor into one address strobe per beat.
// Expects descriptors already checked for legality; no back-pressure on beats.
`default_nettype none

module aw_beat_gen (
    input  logic                 rclk,
    input  logic                 rrst,
    input  logic                 empty,
    input  aw_cdc_pkg::aw_desc_t rdata,
    output logic                 pop,
    output logic                 beat_valid,
    output aw_cdc_pkg::aw_beat_t beat
);

    import aw_cdc_pkg::*;

    typedef enum logic {
        st_idle,
        st_burst
    } state_e;

    state_e            state;
    logic [len_w-1:0]  beats_left;
    logic              last_beat;

    // Per-burst values, loaded on pop
    logic [id_w-1:0]   id_r;
    burst_e            burst_r;
    logic [addr_w-1:0] cur_addr;
    logic [addr_w-1:0] step;
    logic [addr_w-1:0] wrap_base;
    logic [addr_w-1:0] wrap_mask;

    logic [addr_w-1:0] load_step;
    logic [addr_w-1:0] load_mask;
    logic [addr_w-1:0] incr_addr;

    assign last_beat = (state == st_burst) && (beats_left == '0);

    // Take the next descriptor when idle or on the final beat
    assign pop = !empty && ((state == st_idle) || last_beat);

    // Bytes per beat and wrap window of the head entry
    assign load_step = {{(addr_w-1){1'b0}}, 1'b1} << rdata.size;
    assign load_mask = (({{(addr_w-len_w){1'b0}}, rdata.len} + 1'b1) << rdata.size) - 1'b1;

    assign incr_addr = cur_addr + step;

    always_ff @(posedge rclk) begin
        if (rrst) begin
            state      <= st_idle;
            beats_left <= '0;
        end else if (pop) begin
            state      <= st_burst;
            beats_left <= rdata.len;
        end else if (last_beat) begin
            state <= st_idle;
        end else if (state == st_burst) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    always_ff @(posedge rclk) begin
        if (pop) begin
            id_r      <= rdata.id;
            burst_r   <= rdata.burst;
            cur_addr  <= rdata.addr;
            step      <= load_step;
            wrap_mask <= load_mask;
            wrap_base <= rdata.addr & ~load_mask;
        end else if (state == st_burst) begin
            case (burst_r)
                burst_incr: cur_addr <= incr_addr;
                burst_wrap: cur_addr <= wrap_base | (incr_addr & wrap_mask);
                // FIXED holds the start address
                default:    cur_addr <= cur_addr;
            endcase
        end
    end

    assign beat_valid = (state == st_burst);
    assign beat.id    = id_r;
    assign beat.addr  = cur_addr;
    assign beat.last  = last_beat;

endmodule : aw_beat_gen

`default_nettype wire

// ==== hw/aw_cdc_top.sv ====
// AW channel bridge from the wclk domain to the rclk domain.
// Input and output are single-cycle strobes without back-pressure;
// descriptors that find the FIFO full are dropped and counted.
`default_nettype none

module aw_cdc_top #(
    parameter int fifo_aw  = 2,
    parameter int max_size = 2
) (
    input  logic                         wclk,
    input  logic                         wrst,
    input  logic                         aw_valid,
    input  aw_cdc_pkg::aw_desc_t         aw_in,
    output logic [aw_cdc_pkg::cnt_w-1:0] reject_count,
    output logic [aw_cdc_pkg::cnt_w-1:0] drop_count,

    input  logic                         rclk,
    input  logic                         rrst,
    output logic                         beat_valid,
    output aw_cdc_pkg::aw_beat_t         beat
);

    import aw_cdc_pkg::*;

    // wclk domain
    logic     push;
    aw_desc_t wdata;
    logic     full;

    // rclk domain
    logic     pop;
    aw_desc_t rdata;
    logic     empty;

    aw_admit #(
        .max_size(max_size)
    ) u_admit (
        .wclk        (wclk),
        .wrst        (wrst),
        .aw_valid    (aw_valid),
        .aw_in       (aw_in),
        .full        (full),
        .push        (push),
        .wdata       (wdata),
        .reject_count(reject_count),
        .drop_count  (drop_count)
    );

    aw_async_fifo #(
        .fifo_aw(fifo_aw)
    ) u_fifo (
        .wclk (wclk),
        .wrst (wrst),
        .push (push),
        .wdata(wdata),
        .full (full),
        .rclk (rclk),
        .rrst (rrst),
        .pop  (pop),
        .rdata(rdata),
        .empty(empty)
    );

    aw_beat_gen u_beat_gen (
        .rclk      (rclk),
        .rrst      (rrst),
        .empty     (empty),
        .rdata     (rdata),
        .pop       (pop),
        .beat_valid(beat_valid),
        .beat      (beat)
    );

endmodule : aw_cdc_top

`default_nettype wire

// ==== tests/aw_cdc_checker.sv ====
// Assertions bound into aw_cdc_top, watching the FIFO handshake nets and the outputs.
// fail_count is read by the testbench at the end of the run.
`default_nettype none

module aw_cdc_checker (
    input logic                         wclk,
    input logic                         wrst,
    input logic                         push,
    input logic                         full,
    input logic                         rclk,
    input logic                         rrst,
    input logic                         pop,
    input logic                         empty,
    input logic                         beat_valid,
    input logic [aw_cdc_pkg::cnt_w-1:0] drop_count
);

    int fail_count = 0;

    // Admit must never write into a full FIFO
    a_push_full : assert property (@(posedge wclk) disable iff (wrst) !(push && full))
        else begin
            $error("push while FIFO full");
            fail_count++;
        end

    a_pop_empty : assert property (@(posedge rclk) disable iff (rrst) !(pop && empty))
        else begin
            $error("pop while FIFO empty");
            fail_count++;
        end

    // Output stays quiet while the read side is held in reset
    a_beat_reset : assert property (@(posedge rclk) rrst |=> !beat_valid)
        else begin
            $error("beat_valid high during reset");
            fail_count++;
        end

    a_drop_mono : assert property (@(posedge wclk) disable iff (wrst)
                                   drop_count >= $past(drop_count))
        else begin
            $error("drop_count decreased");
            fail_count++;
        end

endmodule : aw_cdc_checker

bind aw_cdc_top aw_cdc_checker u_checker (
    .wclk      (wclk),
    .wrst      (wrst),
    .push      (push),
    .full      (full),
    .rclk      (rclk),
    .rrst      (rrst),
    .pop       (pop),
    .empty     (empty),
    .beat_valid(beat_valid),
    .drop_count(drop_count)
);

`default_nettype wire

// ==== tests/aw_cdc_tb.sv ====
// Testbench for the AW bridge; wclk (14) and rclk (20) drift against each other.
// Descriptor ids must be unique over the run, so fewer than 256 are sent.
`default_nettype none

module aw_cdc_tb;

    import aw_cdc_pkg::*;

    localparam int fifo_aw  = 2;
    localparam int max_size = 2;

    logic             wclk;
    logic             wrst;
    logic             aw_valid;
    aw_desc_t         aw_in;
    logic [cnt_w-1:0] reject_count;
    logic [cnt_w-1:0] drop_count;
    logic             rclk;
    logic             rrst;
    logic             beat_valid;
    aw_beat_t         beat;

    aw_desc_t          exp_q[$];
    aw_desc_t          cur_desc;
    int                beat_idx       = 0;
    int                bursts_done    = 0;
    bit                skip_ok        = 1'b0;
    int                seed           = 32'h856b_580e;
    logic [id_w-1:0]   next_id        = '0;
    logic [addr_w-1:0] last_beat_addr = '0;
    int                wrap_lens[4]   = '{1, 3, 7, 15};

    aw_cdc_top #(
        .fifo_aw (fifo_aw),
        .max_size(max_size)
    ) UUT (
        .wclk        (wclk),
        .wrst        (wrst),
        .aw_valid    (aw_valid),
        .aw_in       (aw_in),
        .reject_count(reject_count),
        .drop_count  (drop_count),
        .rclk        (rclk),
        .rrst        (rrst),
        .beat_valid  (beat_valid),
        .beat        (beat)
    );

    initial begin
        wclk = 1'b0;
        forever #7 wclk = ~wclk;
    end

    initial begin
        rclk = 1'b0;
        forever #10 rclk = ~rclk;
    end

    task automatic abort_run(input string why);
        $display("ERROR time=%0t: %s", $time, why);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic bit is_legal(input aw_desc_t d);
        if (d.burst == burst_rsvd || d.size > max_size) begin
            return 1'b0;
        end
        if (d.burst == burst_wrap) begin
            if (!(d.len inside {1, 3, 7, 15}) || (d.addr % (32'd1 << d.size)) != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Address of beat i from the AXI FIXED, INCR and WRAP rules
    function automatic logic [addr_w-1:0] beat_addr(input aw_desc_t d, input int i);
        longint unsigned bytes;
        longint unsigned total;
        longint unsigned base;
        bytes = 64'd1 << d.size;
        total = (d.len + 64'd1) * bytes;
        base  = d.addr - (d.addr % total);
        case (d.burst)
            burst_incr: return d.addr + i * bytes;
            burst_wrap: return base + ((d.addr - base + i * bytes) % total);
            default:    return d.addr;
        endcase
    endfunction

    task automatic build_legal(input burst_e b, input int len, output aw_desc_t d);
        d.id    = next_id;
        next_id = next_id + 1'b1;
        d.burst = b;
        d.len   = 4'(len);
        d.size  = 3'($unsigned($random(seed)) % (max_size + 1));
        d.addr  = $random(seed);
        if (b == burst_wrap) begin
            d.addr = d.addr & ~((32'd1 << d.size) - 1);
        end
    endtask

    // One strobe then one idle wclk cycle
    task automatic send_desc(input aw_desc_t d);
        @(posedge wclk);
        aw_valid <= 1'b1;
        aw_in    <= d;
        if (is_legal(d)) begin
            exp_q.push_back(d);
        end
        @(posedge wclk);
        aw_valid <= 1'b0;
    endtask

    task automatic wait_bursts(input int target);
        int n;
        n = 0;
        while (bursts_done < target) begin
            @(posedge rclk);
            n++;
            if (n > 1000) begin
                abort_run("timeout waiting for expected bursts");
            end
        end
    endtask

    // Beat checker that skips dropped descriptors by id in overflow mode
    always @(negedge rclk) begin
        if (!rrst && beat_valid) begin
            if (beat_idx == 0) begin
                while (skip_ok && exp_q.size() > 0 && exp_q[0].id != beat.id) begin
                    exp_q.delete(0);
                end
                if (exp_q.size() == 0) begin
                    abort_run("beat arrived with no expected burst");
                end
                cur_desc = exp_q.pop_front();
            end
            check_value("beat.id", beat.id, cur_desc.id);
            check_value("beat.addr", beat.addr, beat_addr(cur_desc, beat_idx));
            check_value("beat.last", beat.last, beat_idx == cur_desc.len);
            if (beat_idx == cur_desc.len) begin
                last_beat_addr = beat.addr;
                beat_idx = 0;
                bursts_done++;
            end else begin
                beat_idx++;
            end
        end
    end

    initial begin
        aw_desc_t d;
        int       base_done;
        int       n;
        aw_valid = 1'b0;
        aw_in    = '0;
        wrst     = 1'b1;
        rrst     = 1'b1;
        fork
            begin
                repeat (16) @(posedge wclk);
                wrst <= 1'b0;
            end
            begin
                repeat (16) @(posedge rclk);
                rrst <= 1'b0;
            end
        join

        // Idle after reset
        repeat (100) begin
            @(negedge rclk);
            check_value("beat_valid", beat_valid, 1'b0);
            check_value("reject_count", reject_count, 0);
            check_value("drop_count", drop_count, 0);
        end

        // Spaced bursts of all three types
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 2) begin
                build_legal(burst_wrap, wrap_lens[$unsigned($random(seed)) % 4], d);
            end else begin
                build_legal(burst_e'(i % 3), $unsigned($random(seed)) % 16, d);
            end
            send_desc(d);
            wait_bursts(bursts_done + 1);
        end

        // WRAP starting mid-window must fold back to base 0x...30
        build_legal(burst_wrap, 3, d);
        d.size = 3'd2;
        d.addr = 32'h1000_0034;
        send_desc(d);
        wait_bursts(bursts_done + 1);
        check_value("wrap last beat addr", last_beat_addr, 32'h1000_0030);

        // Four illegal descriptors then a legal marker burst
        build_legal(burst_incr, 3, d);
        d.burst = burst_rsvd;
        send_desc(d);
        d.burst = burst_incr;
        d.size  = 3'(max_size + 1);
        send_desc(d);
        build_legal(burst_wrap, 2, d);
        send_desc(d);
        build_legal(burst_wrap, 7, d);
        d.size = 3'd2;
        d.addr = 32'h0000_0402;
        send_desc(d);
        build_legal(burst_incr, 1, d);
        send_desc(d);
        wait_bursts(bursts_done + 1);
        check_value("reject_count", reject_count, 4);
        check_value("drop_count", drop_count, 0);
        check_value("pending bursts", exp_q.size(), 0);

        // Back-to-back bursts that still fit in the FIFO
        base_done = bursts_done;
        for (int i = 0; i < 4; i++) begin
            build_legal((i % 2 == 0) ? burst_incr : burst_wrap, 7, d);
            send_desc(d);
        end
        wait_bursts(base_done + 4);
        check_value("drop_count", drop_count, 0);

        // Overflow with a strobe every wclk cycle and long bursts
        skip_ok   = 1'b1;
        base_done = bursts_done;
        for (int i = 0; i < 20; i++) begin
            build_legal(burst_incr, 15, d);
            @(posedge wclk);
            aw_valid <= 1'b1;
            aw_in    <= d;
            exp_q.push_back(d);
        end
        @(posedge wclk);
        aw_valid <= 1'b0;
        n = 0;
        while ((bursts_done - base_done) + int'(drop_count) < 20) begin
            @(posedge rclk);
            n++;
            if (n > 3000) begin
                abort_run("timeout waiting for overflow run to drain");
            end
        end
        repeat (60) @(posedge rclk);
        check_value("bursts plus drops", (bursts_done - base_done) + int'(drop_count), 20);
        check_value("overflow occurred", drop_count != 0, 1'b1);
        exp_q.delete();
        skip_ok = 1'b0;

        if (UUT.u_checker.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("checker assertions failed");
        end
    end

endmodule : aw_cdc_tb

`default_nettype wire

// ==== aw_cdc.f ====
hw/aw_cdc_pkg.sv
hw/gray_sync.sv
hw/aw_async_fifo.sv
hw/aw_admit.sv
hw/aw_beat_gen.sv
hw/aw_cdc_top.sv
tests/aw_cdc_checker.sv
tests/aw_cdc_tb.sv
